// ==== src/fpu_pkg.sv ====
// shared definitions for the byte-wide single-precision coprocessor
// subnormals are flushed to zero, no NaN or infinity handling
// register map is one byte per address, least significant byte first

package fpu_pkg;

  // ------------------------------------------------------------------------
  // float format
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic       sign;
    logic [7:0] exp;
    logic [22:0] frac;
  } float_t;

  localparam logic [7:0] EXP_BIAS = 8'd127;
  localparam int MAN_W = 23;
  // guard, round and sticky below the add/sub mantissa
  localparam int GUARD_W = 3;

  // operands come out of reset as 1.0
  localparam float_t ONE_F = 32'h3F80_0000;

  // unknown codes complete at once with a zero result
  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_mul = 4'd2
  } op_t;

  // ------------------------------------------------------------------------
  // register map
  // ------------------------------------------------------------------------
  localparam logic [3:0] ADDR_A0 = 4'h0;
  localparam logic [3:0] ADDR_A1 = 4'h1;
  localparam logic [3:0] ADDR_A2 = 4'h2;
  localparam logic [3:0] ADDR_A3 = 4'h3;
  localparam logic [3:0] ADDR_B0 = 4'h4;
  localparam logic [3:0] ADDR_B1 = 4'h5;
  localparam logic [3:0] ADDR_B2 = 4'h6;
  localparam logic [3:0] ADDR_B3 = 4'h7;
  localparam logic [3:0] ADDR_OP = 4'h8;
  // start on write, result byte 0 on read
  localparam logic [3:0] ADDR_START = 4'h9;
  localparam logic [3:0] ADDR_R0 = 4'h9;
  localparam logic [3:0] ADDR_R1 = 4'hA;
  localparam logic [3:0] ADDR_R2 = 4'hB;
  localparam logic [3:0] ADDR_R3 = 4'hC;

endpackage

// ==== src/fpu_regs.sv ====
// bus register file with active-low cs/rd/wr strobes
// writes to operands, operation and start are dropped while busy
// read bus is combinational and shows zero when not selected

`timescale 1ns/1ps

module fpu_regs (
  input  logic               clk,
  input  logic               arst,
  input  logic               cs,
  input  logic               rd,
  input  logic               wr,
  input  logic [3:0]         addr,
  input  logic [7:0]         databus_in,
  output logic [7:0]         databus_out,
  input  logic               busy,
  input  logic               accept,
  input  logic               load_result,
  input  fpu_pkg::float_t    result,
  output fpu_pkg::float_t    operand_a,
  output fpu_pkg::float_t    operand_b,
  output fpu_pkg::op_t       op,
  output logic               start_req
);

  logic wr_en;

  assign wr_en = !cs && !wr && !busy;

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      operand_a <= fpu_pkg::ONE_F;
      operand_b <= fpu_pkg::ONE_F;
      op        <= fpu_pkg::op_add;
      start_req <= 1'b0;
    end else begin
      if (accept) begin
        start_req <= 1'b0;
      end
      // chain the result into operand a
      if (load_result) begin
        operand_a <= result;
      end
      if (wr_en) begin
        case (addr)
          fpu_pkg::ADDR_A0:    operand_a[7:0]   <= databus_in;
          fpu_pkg::ADDR_A1:    operand_a[15:8]  <= databus_in;
          fpu_pkg::ADDR_A2:    operand_a[23:16] <= databus_in;
          fpu_pkg::ADDR_A3:    operand_a[31:24] <= databus_in;
          fpu_pkg::ADDR_B0:    operand_b[7:0]   <= databus_in;
          fpu_pkg::ADDR_B1:    operand_b[15:8]  <= databus_in;
          fpu_pkg::ADDR_B2:    operand_b[23:16] <= databus_in;
          fpu_pkg::ADDR_B3:    operand_b[31:24] <= databus_in;
          fpu_pkg::ADDR_OP:    op <= fpu_pkg::op_t'(databus_in[3:0]);
          fpu_pkg::ADDR_START: start_req <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // readback mux
  always_comb begin
    databus_out = 8'h00;
    if (!cs && !rd) begin
      case (addr)
        fpu_pkg::ADDR_A0: databus_out = operand_a[7:0];
        fpu_pkg::ADDR_A1: databus_out = operand_a[15:8];
        fpu_pkg::ADDR_A2: databus_out = operand_a[23:16];
        fpu_pkg::ADDR_A3: databus_out = operand_a[31:24];
        fpu_pkg::ADDR_B0: databus_out = operand_b[7:0];
        fpu_pkg::ADDR_B1: databus_out = operand_b[15:8];
        fpu_pkg::ADDR_B2: databus_out = operand_b[23:16];
        fpu_pkg::ADDR_B3: databus_out = operand_b[31:24];
        fpu_pkg::ADDR_OP: databus_out = {4'h0, op};
        fpu_pkg::ADDR_R0: databus_out = result[7:0];
        fpu_pkg::ADDR_R1: databus_out = result[15:8];
        fpu_pkg::ADDR_R2: databus_out = result[23:16];
        fpu_pkg::ADDR_R3: databus_out = result[31:24];
        default:          databus_out = 8'h00;
      endcase
    end
  end

endmodule

// ==== src/fpu_sequencer.sv ====
// control FSM, one operation in flight at a time
// cmd_end is held until end_ack is seen at an edge
// unknown operation codes finish with a zero result

`timescale 1ns/1ps

module fpu_sequencer (
  input  logic            clk,
  input  logic            arst,
  input  logic            start_req,
  input  fpu_pkg::op_t    op,
  input  logic            end_ack,
  input  fpu_pkg::float_t addsub_result,
  input  logic            mul_done,
  input  fpu_pkg::float_t mul_result,
  output logic            accept,
  output logic            mul_start,
  output logic            load_result,
  output logic            busy,
  output logic            cmd_end,
  output fpu_pkg::float_t result
);

  typedef enum logic [1:0] {
    st_idle,
    st_exec,
    st_mul_wait,
    st_ack
  } state_t;

  state_t state;

  // take the request as soon as we are idle
  assign accept    = (state == st_idle) && start_req;
  assign mul_start = accept && (op == fpu_pkg::op_mul);
  assign busy      = (state != st_idle);

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state       <= st_idle;
      result      <= '0;
      load_result <= 1'b0;
      cmd_end     <= 1'b0;
    end else begin
      load_result <= 1'b0;
      case (state)
        st_idle: begin
          if (start_req) begin
            if (op == fpu_pkg::op_mul) begin
              state <= st_mul_wait;
            end else begin
              state <= st_exec;
            end
          end
        end
        // add/sub result is ready one cycle after start
        st_exec: begin
          if (op == fpu_pkg::op_add || op == fpu_pkg::op_sub) begin
            result <= addsub_result;
          end else begin
            result <= '0;
          end
          load_result <= 1'b1;
          state       <= st_ack;
        end
        st_mul_wait: begin
          if (mul_done) begin
            result      <= mul_result;
            load_result <= 1'b1;
            state       <= st_ack;
          end
        end
        st_ack: begin
          if (cmd_end && end_ack) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase

      // cmd_end rises on the same edge as the operand a copy
      if (load_result) begin
        cmd_end <= 1'b1;
      end else if (cmd_end && end_ack) begin
        cmd_end <= 1'b0;
      end
    end
  end

endmodule

// ==== src/fpu_addsub.sv ====
// combinational add/subtract, round to nearest even
// zero exponent inputs are taken as zero, exact zero gives +0
// no overflow or underflow detection

`timescale 1ns/1ps

module fpu_addsub (
  input  fpu_pkg::float_t operand_a,
  input  fpu_pkg::float_t operand_b,
  input  fpu_pkg::op_t    op,
  output fpu_pkg::float_t sum
);

  // sign, carry, hidden one, fraction, guard bits
  localparam int MW = fpu_pkg::MAN_W + fpu_pkg::GUARD_W + 3;
  localparam int GW = fpu_pkg::GUARD_W;

  logic [MW-1:0]  man_a;
  logic [MW-1:0]  man_b;
  logic [MW-1:0]  small_m;
  logic [MW-1:0]  mask;
  logic [MW-1:0]  aligned;
  logic [MW-1:0]  term_a;
  logic [MW-1:0]  term_b;
  logic [MW-1:0]  total;
  logic [MW-1:0]  mag;
  logic [MW-1:0]  norm;
  logic [7:0]     exp_max;
  logic [7:0]     diff;
  logic           a_is_big;
  logic           sticky;
  logic           neg_b;
  logic           res_sign;
  logic [4:0]     lead;
  logic [4:0]     lshift;
  logic [9:0]     exp_n;
  logic           round_up;
  logic [fpu_pkg::MAN_W+1:0] rounded;
  logic [fpu_pkg::MAN_W-1:0] frac;

  // flush subnormals, add hidden one
  assign man_a = (operand_a.exp == 8'd0) ? '0 :
                 {2'b00, 1'b1, operand_a.frac, {GW{1'b0}}};
  assign man_b = (operand_b.exp == 8'd0) ? '0 :
                 {2'b00, 1'b1, operand_b.frac, {GW{1'b0}}};

  // ------------------------------------------------------------------------
  // alignment with sticky collection
  // ------------------------------------------------------------------------
  assign a_is_big = (operand_a.exp >= operand_b.exp);
  assign exp_max  = a_is_big ? operand_a.exp : operand_b.exp;
  assign diff     = a_is_big ? operand_a.exp - operand_b.exp : operand_b.exp - operand_a.exp;
  assign small_m  = a_is_big ? man_b : man_a;
  assign mask     = ~({MW{1'b1}} << diff);
  assign sticky   = |(small_m & mask);
  assign aligned  = (small_m >> diff) | MW'(sticky);

  // two's complement terms, sub flips the sign of b
  assign neg_b  = operand_b.sign ^ (op == fpu_pkg::op_sub);
  assign term_a = operand_a.sign ? -(a_is_big ? man_a : aligned) : (a_is_big ? man_a : aligned);
  assign term_b = neg_b ? -(a_is_big ? aligned : man_b) : (a_is_big ? aligned : man_b);

  assign total    = term_a + term_b;
  assign res_sign = total[MW-1];
  assign mag      = res_sign ? -total : total;

  // ------------------------------------------------------------------------
  // normalize and round
  // ------------------------------------------------------------------------
  always_comb begin
    lead = 5'd0;
    for (int i = 0; i < MW - 2; i++) begin
      if (mag[i]) begin
        lead = 5'(i);
      end
    end
    lshift = 5'(MW - 3) - lead;

    if (mag[MW-2]) begin
      // carry out, keep the dropped bit in sticky
      norm  = (mag >> 1) | MW'(mag[0]);
      exp_n = {2'b00, exp_max} + 10'd1;
    end else begin
      norm  = mag << lshift;
      exp_n = {2'b00, exp_max} - {5'd0, lshift};
    end

    // ties go to the even neighbour
    round_up = norm[GW-1] & ((|norm[GW-2:0]) | norm[GW]);
    rounded  = {1'b0, norm[MW-3:GW]} + {{(fpu_pkg::MAN_W+1){1'b0}}, round_up};

    if (rounded[fpu_pkg::MAN_W+1]) begin
      exp_n = exp_n + 10'd1;
      frac  = rounded[fpu_pkg::MAN_W:1];
    end else begin
      frac = rounded[fpu_pkg::MAN_W-1:0];
    end

    if (mag == '0) begin
      sum = '0;
    end else begin
      sum = {res_sign, exp_n[7:0], frac};
    end
  end

endmodule

// ==== src/fpu_multiplier.sv ====
// sequential shift-and-add multiplier, 24 add/shift step pairs
// fraction is truncated after a one place normalization
// zero operand gives +0, exponent overflow is not detected

`timescale 1ns/1ps

module fpu_multiplier (
  input  logic            clk,
  input  logic            arst,
  input  logic            mul_start,
  input  fpu_pkg::float_t operand_a,
  input  fpu_pkg::float_t operand_b,
  output logic            mul_done,
  output fpu_pkg::float_t mul_result
);

  localparam int STEPS = 24;
  localparam int MW = fpu_pkg::MAN_W + 1;

  typedef enum logic [2:0] {
    m_idle,
    m_setup,
    m_add,
    m_shift,
    m_result
  } mstate_t;

  mstate_t       state;
  logic [4:0]    step;
  logic [MW-1:0] multiplicand;
  // product in the upper half, multiplier shifting out of the lower half
  logic [2*MW:0] prod;
  logic          sign_r;
  logic          zero_r;
  logic [9:0]    exp_r;

  // ------------------------------------------------------------------------
  // step control
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state    <= m_idle;
      step     <= 5'd0;
      mul_done <= 1'b0;
    end else begin
      mul_done <= 1'b0;
      case (state)
        m_idle: begin
          if (mul_start) begin
            state <= m_setup;
          end
        end
        m_setup: begin
          step  <= 5'd0;
          state <= m_add;
        end
        m_add: begin
          step  <= step + 5'd1;
          state <= m_shift;
        end
        m_shift: begin
          if (step == 5'(STEPS)) begin
            state <= m_result;
          end else begin
            state <= m_add;
          end
        end
        m_result: begin
          mul_done <= 1'b1;
          state    <= m_idle;
        end
        default: state <= m_idle;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    case (state)
      m_setup: begin
        multiplicand <= {1'b1, operand_a.frac};
        prod         <= {{(MW+1){1'b0}}, 1'b1, operand_b.frac};
        sign_r       <= operand_a.sign ^ operand_b.sign;
        zero_r       <= (operand_a.exp == 8'd0) || (operand_b.exp == 8'd0);
        exp_r        <= {2'b00, operand_a.exp} + {2'b00, operand_b.exp} -
                        {2'b00, fpu_pkg::EXP_BIAS};
      end
      m_add: begin
        if (prod[0]) begin
          prod[2*MW:MW] <= prod[2*MW:MW] + {1'b0, multiplicand};
        end
      end
      m_shift: begin
        prod <= prod >> 1;
      end
      m_result: begin
        if (zero_r) begin
          mul_result <= '0;
        end else if (prod[2*MW-1]) begin
          // product in [2,4), bump the exponent
          mul_result <= {sign_r, exp_r[7:0] + 8'd1, prod[2*MW-2 -: fpu_pkg::MAN_W]};
        end else begin
          mul_result <= {sign_r, exp_r[7:0], prod[2*MW-3 -: fpu_pkg::MAN_W]};
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== src/fpu.sv ====
// memory-mapped single-precision coprocessor, add/sub/mul only
// host writes operands and op, then writes start and waits for cmd_end
// the result is also copied into operand a for chaining

`timescale 1ns/1ps

module fpu (
  input  logic       clk,
  input  logic       arst,
  input  logic       cs,
  input  logic       rd,
  input  logic       wr,
  input  logic [3:0] addr,
  input  logic [7:0] databus_in,
  output logic [7:0] databus_out,
  input  logic       end_ack,
  output logic       cmd_end,
  output logic       busy
);

  fpu_pkg::float_t operand_a;
  fpu_pkg::float_t operand_b;
  fpu_pkg::op_t    op;
  fpu_pkg::float_t addsub_result;
  fpu_pkg::float_t mul_result;
  fpu_pkg::float_t result;
  logic            start_req;
  logic            accept;
  logic            load_result;
  logic            mul_start;
  logic            mul_done;

  fpu_regs regs0 (
    .clk         (clk),
    .arst        (arst),
    .cs          (cs),
    .rd          (rd),
    .wr          (wr),
    .addr        (addr),
    .databus_in  (databus_in),
    .databus_out (databus_out),
    .busy        (busy),
    .accept      (accept),
    .load_result (load_result),
    .result      (result),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .op          (op),
    .start_req   (start_req)
  );

  fpu_sequencer seq0 (
    .clk           (clk),
    .arst          (arst),
    .start_req     (start_req),
    .op            (op),
    .end_ack       (end_ack),
    .addsub_result (addsub_result),
    .mul_done      (mul_done),
    .mul_result    (mul_result),
    .accept        (accept),
    .mul_start     (mul_start),
    .load_result   (load_result),
    .busy          (busy),
    .cmd_end       (cmd_end),
    .result        (result)
  );

  fpu_addsub addsub0 (
    .operand_a (operand_a),
    .operand_b (operand_b),
    .op        (op),
    .sum       (addsub_result)
  );

  fpu_multiplier mul0 (
    .clk        (clk),
    .arst       (arst),
    .mul_start  (mul_start),
    .operand_a  (operand_a),
    .operand_b  (operand_b),
    .mul_done   (mul_done),
    .mul_result (mul_result)
  );

endmodule

// ==== testbench/fpu_chk.sv ====
// concurrent checks on the cmd_end/end_ack exchange, bound into fpu
// fail_count holds the number of failed assertions

`timescale 1ns/1ps

module fpu_chk (
  input logic clk,
  input logic arst,
  input logic busy,
  input logic cmd_end,
  input logic end_ack
);

  int fail_count = 0;

  a_end_busy: assert property (@(posedge clk) disable iff (arst) cmd_end |-> busy)
    else begin
      $error("cmd_end high while busy is low");
      fail_count++;
    end

  // cmd_end only drops on an acknowledge
  a_end_hold: assert property (@(posedge clk) disable iff (arst)
                               cmd_end && !end_ack |=> cmd_end)
    else begin
      $error("cmd_end dropped without end_ack");
      fail_count++;
    end

  a_reset_idle: assert property (@(posedge clk) $fell(arst) |-> !busy && !cmd_end)
    else begin
      $error("busy or cmd_end high after reset release");
      fail_count++;
    end

endmodule

bind fpu fpu_chk chk0 (
  .clk     (clk),
  .arst    (arst),
  .busy    (busy),
  .cmd_end (cmd_end),
  .end_ack (end_ack)
);

// ==== testbench/fpu_tb.sv ====
// testbench for the fpu coprocessor, vectors from testbench/fpu_testdata.txt
// run from the project root so the data file path resolves
// bus inputs change 1 ns after the rising edge, reads sample mid-cycle

`timescale 1ns/1ps

module fpu_tb;

  localparam int CMD_TIMEOUT = 150;

  logic       clk;
  logic       arst;
  logic       cs;
  logic       rd;
  logic       wr;
  logic [3:0] addr;
  logic [7:0] databus_in;
  logic [7:0] databus_out;
  logic       end_ack;
  logic       cmd_end;
  logic       busy;

  int value_errors = 0;
  int other_errors = 0;
  bit loaded = 1'b0;

  logic [3:0]      vec_op[$];
  fpu_pkg::float_t vec_a[$];
  fpu_pkg::float_t vec_b[$];
  fpu_pkg::float_t vec_exp[$];
  bit              vec_chain[$];

  fpu dut0 (
    .clk         (clk),
    .arst        (arst),
    .cs          (cs),
    .rd          (rd),
    .wr          (wr),
    .addr        (addr),
    .databus_in  (databus_in),
    .databus_out (databus_out),
    .end_ack     (end_ack),
    .cmd_end     (cmd_end),
    .busy        (busy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_float(input string name, input fpu_pkg::float_t expd,
                             input fpu_pkg::float_t act);
    logic [31:0] e_w;
    logic [31:0] a_w;
    e_w = expd;
    a_w = act;
    if (a_w !== e_w) begin
      value_errors++;
      $display("error: %s expected %h actual %h", name, e_w, a_w);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] expd, input logic [7:0] act);
    if (act !== expd) begin
      value_errors++;
      $display("error: %s expected %h actual %h", name, expd, act);
    end
  endtask

  task automatic check_bit(input string name, input logic expd, input logic act);
    if (act !== expd) begin
      value_errors++;
      $display("error: %s expected %h actual %h", name, expd, act);
    end
  endtask

  // --------------------------------------------------------------------------
  // bus access
  // --------------------------------------------------------------------------
  task automatic bus_write(input logic [3:0] a, input logic [7:0] d);
    @(posedge clk);
    #1;
    cs = 1'b0;
    wr = 1'b0;
    addr = a;
    databus_in = d;
    @(posedge clk);
    #1;
    cs = 1'b1;
    wr = 1'b1;
  endtask

  task automatic bus_read(input logic [3:0] a, output logic [7:0] d);
    @(posedge clk);
    #1;
    cs = 1'b0;
    rd = 1'b0;
    addr = a;
    #3;
    d = databus_out;
    @(posedge clk);
    #1;
    cs = 1'b1;
    rd = 1'b1;
  endtask

  // least significant byte at the lowest address
  task automatic write_word(input logic [3:0] base, input fpu_pkg::float_t w);
    logic [31:0] bits;
    bits = w;
    for (int i = 0; i < 4; i++) begin
      bus_write(base + 4'(i), bits[8*i +: 8]);
    end
  endtask

  task automatic read_word(input logic [3:0] base, output fpu_pkg::float_t w);
    logic [31:0] bits;
    logic [7:0]  d;
    bits = '0;
    for (int i = 0; i < 4; i++) begin
      bus_read(base + 4'(i), d);
      bits[8*i +: 8] = d;
    end
    w = bits;
  endtask

  task automatic wait_cmd_end(output bit ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < CMD_TIMEOUT) begin
      @(posedge clk);
      #1;
      if (cmd_end) begin
        ok = 1'b1;
      end
      n++;
    end
    if (!ok) begin
      other_errors++;
      $display("timeout: cmd_end did not rise within %0d cycles", CMD_TIMEOUT);
    end
  endtask

  task automatic ack_end();
    @(posedge clk);
    #1;
    end_ack = 1'b1;
    @(posedge clk);
    #1;
    end_ack = 1'b0;
    check_bit("cmd_end after ack", 1'b0, cmd_end);
    check_bit("busy after ack", 1'b0, busy);
  endtask

  // --------------------------------------------------------------------------
  // test data
  // --------------------------------------------------------------------------
  task automatic load_vectors();
    int          fd;
    int          rc;
    int          n;
    string       line;
    logic [3:0]  f_op;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_exp;
    logic [3:0]  f_chain;
    fd = $fopen("testbench/fpu_testdata.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open the test data file");
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        n = 0;
        // comment lines do not scan as five fields
        if (rc > 0) begin
          n = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_exp, f_chain);
        end
        if (n == 5) begin
          vec_op.push_back(f_op);
          vec_a.push_back(f_a);
          vec_b.push_back(f_b);
          vec_exp.push_back(f_exp);
          vec_chain.push_back(f_chain != 4'h0);
        end
      end
      $fclose(fd);
    end
    if (vec_op.size() == 0) begin
      other_errors++;
      $display("no test vectors were loaded");
    end
  endtask

  // --------------------------------------------------------------------------
  // test sequences
  // --------------------------------------------------------------------------
  task automatic check_reset_state();
    logic [31:0] one_w;
    logic [7:0]  d;
    one_w = fpu_pkg::ONE_F;
    check_bit("busy", 1'b0, busy);
    check_bit("cmd_end", 1'b0, cmd_end);
    check_byte("databus_out deselected", 8'h00, databus_out);
    for (int i = 0; i < 4; i++) begin
      bus_read(fpu_pkg::ADDR_A0 + 4'(i), d);
      check_byte($sformatf("operand_a byte %0d", i), one_w[8*i +: 8], d);
      bus_read(fpu_pkg::ADDR_B0 + 4'(i), d);
      check_byte($sformatf("operand_b byte %0d", i), one_w[8*i +: 8], d);
      bus_read(fpu_pkg::ADDR_R0 + 4'(i), d);
      check_byte($sformatf("result byte %0d", i), 8'h00, d);
    end
    bus_read(fpu_pkg::ADDR_OP, d);
    check_byte("op", 8'h00, d);
  endtask

  task automatic check_register_access();
    logic [7:0] pat;
    logic [7:0] d;
    for (int i = 0; i <= 8; i++) begin
      // op holds four bits only
      pat = (i == 8) ? 8'h07 : {4'(i), ~4'(i)};
      bus_write(4'(i), pat);
      bus_read(4'(i), d);
      check_byte($sformatf("register %0h", i), pat, d);
    end
    for (int i = 13; i < 16; i++) begin
      bus_read(4'(i), d);
      check_byte($sformatf("unmapped %0h", i), 8'h00, d);
    end
  endtask

  task automatic run_vector(input logic [3:0] op_code, input fpu_pkg::float_t a,
                            input fpu_pkg::float_t b, input fpu_pkg::float_t expd,
                            input bit chain);
    fpu_pkg::float_t got;
    bit              ok;
    if (chain) begin
      read_word(fpu_pkg::ADDR_A0, got);
      check_float("operand_a before chain", a, got);
    end else begin
      write_word(fpu_pkg::ADDR_A0, a);
    end
    write_word(fpu_pkg::ADDR_B0, b);
    bus_write(fpu_pkg::ADDR_OP, {4'h0, op_code});
    bus_write(fpu_pkg::ADDR_START, 8'h01);
    @(posedge clk);
    #1;
    check_bit("busy after start", 1'b1, busy);
    // both writes land while busy and must be dropped
    bus_write(fpu_pkg::ADDR_START, 8'h01);
    bus_write(fpu_pkg::ADDR_A0, 8'h5a);
    wait_cmd_end(ok);
    if (ok) begin
      repeat (3) begin
        @(posedge clk);
        #1;
        check_bit("cmd_end held", 1'b1, cmd_end);
        check_bit("busy held", 1'b1, busy);
      end
      read_word(fpu_pkg::ADDR_R0, got);
      check_float("result", expd, got);
      read_word(fpu_pkg::ADDR_A0, got);
      check_float("operand_a", expd, got);
      ack_end();
      repeat (4) @(posedge clk);
      #1;
      check_bit("busy after lost start", 1'b0, busy);
      read_word(fpu_pkg::ADDR_R0, got);
      check_float("result after ack", expd, got);
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    int total;
    arst = 1'b1;
    cs = 1'b1;
    rd = 1'b1;
    wr = 1'b1;
    addr = 4'h0;
    databus_in = 8'h00;
    end_ack = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    arst = 1'b0;
    @(posedge clk);
    #1;
    check_reset_state();
    check_register_access();
    for (int i = 0; i < vec_op.size(); i++) begin
      run_vector(vec_op[i], vec_a[i], vec_b[i], vec_exp[i], vec_chain[i]);
    end
    total = value_errors + other_errors + dut0.chk0.fail_count;
    $display("errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
             dut0.chk0.fail_count);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // 200 cycles per vector plus setup margin
  initial begin
    int limit;
    wait (loaded);
    limit = 200 * vec_op.size() + 1000;
    repeat (limit) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== fpu.f ====
src/fpu_pkg.sv
src/fpu_regs.sv
src/fpu_sequencer.sv
src/fpu_addsub.sv
src/fpu_multiplier.sv
src/fpu.sv
testbench/fpu_chk.sv
testbench/fpu_tb.sv

// ==== Makefile ====
TOP = fpu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f fpu.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" sim.log || \
	  ! grep -q "SIMULATION PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== testbench/fpu_testdata.txt ====
# columns: op a b expected chain, all hex
# chain 1 keeps the last result in operand a, then a is its expected value
0 3F800000 3F800000 40000000 0
0 3FC00000 40100000 40700000 0
1 40490FDB 40490FDB 00000000 0
0 3F800000 BF800000 00000000 0
0 3F800000 C0200000 BFC00000 0
1 40A00000 C0400000 41000000 0
0 3F800000 33800000 3F800000 0
0 3F800001 33800000 3F800002 0
0 3F800000 33800001 3F800001 0
1 3F800000 3F400000 3E800000 0
1 40000000 40400000 BF800000 0
2 40000000 40400000 40C00000 0
0 40C00000 40000000 41000000 1
2 41000000 40000000 41800000 1
2 3FC00000 3FC00000 40100000 0
2 C0200000 40800000 C1200000 0
2 3FFFFFFF 3FFFFFFF 407FFFFE 0
2 00000000 40400000 00000000 0
2 C0000000 00000000 00000000 0
3 40000000 40000000 00000000 0
